//--- all.f
hw/pp_cfg_pkg.sv
hw/pp_port_pkg.sv
hw/pp_write_ctrl.sv
hw/pp_read_ctrl.sv
hw/pp_swap_ctrl.sv
hw/pp_buffer_bank.sv
hw/pingpong_buffer.sv
testbench/pp_checker.sv
testbench/tb_pingpong_buffer.sv

//--- hw/pingpong_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module pingpong_buffer (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    // Producer stream
    input  wire pp_cfg_pkg::sample_t   write_data_i,
    input  wire logic                  write_valid_i,
    output logic                       write_ready_o,

    // Consumer stream
    output pp_cfg_pkg::sample_t        read_data_o,
    output logic                       read_valid_o,
    input  wire logic                  read_ready_i,

    // Status
    output pp_port_pkg::pp_status_t    status_o
);

    // =========================================================================
    // Internal wiring
    // =========================================================================
    pp_port_pkg::bank_wr_t wr;            // Write into the fill bank
    pp_cfg_pkg::addr_t     rd_addr;       // Drain position in read bank
    pp_cfg_pkg::count_t    write_count;
    pp_cfg_pkg::count_t    read_count;
    logic                  full;          // Fill bank complete
    logic                  idle;          // No drain in progress
    logic                  swap;          // Banks exchange on this edge
    logic                  wr_bank_sel;
    logic                  block_ready;

    pp_write_ctrl u_write_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_valid_i (write_valid_i),
        .write_data_i  (write_data_i),
        .swap_i        (swap),
        .write_ready_o (write_ready_o),
        .full_o        (full),
        .wr_o          (wr),
        .write_count_o (write_count)
    );

    pp_read_ctrl u_read_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .read_ready_i (read_ready_i),
        .swap_i       (swap),
        .read_valid_o (read_valid_o),
        .idle_o       (idle),
        .rd_addr_o    (rd_addr),
        .read_count_o (read_count)
    );

    pp_swap_ctrl u_swap_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .full_i        (full),
        .idle_i        (idle),
        .swap_o        (swap),
        .wr_bank_sel_o (wr_bank_sel),
        .block_ready_o (block_ready)
    );

    pp_buffer_bank u_buffer_bank (
        .clk_i         (clk_i),
        .wr_i          (wr),
        .wr_bank_sel_i (wr_bank_sel),
        .rd_addr_i     (rd_addr),
        .rd_data_o     (read_data_o)
    );

    // Status bundle
    always_comb begin
        status_o.block_ready = block_ready;
        status_o.write_count = write_count;
        status_o.read_count  = read_count;
    end

endmodule

`default_nettype wire

//--- hw/pp_buffer_bank.sv
`timescale 1ns/1ps
`default_nettype none

module pp_buffer_bank (
    input  wire logic                  clk_i,
    input  wire pp_port_pkg::bank_wr_t wr_i,            // Write to the fill bank
    input  wire logic                  wr_bank_sel_i,   // Which bank is filling
    input  wire pp_cfg_pkg::addr_t     rd_addr_i,       // Slot in the other bank
    output pp_cfg_pkg::sample_t        rd_data_o
);

    // =========================================================================
    // Storage
    // =========================================================================
    // Two banks of DEPTH samples, first index picks the bank
    pp_cfg_pkg::sample_t mem_q [2][pp_cfg_pkg::DEPTH];

    logic rd_bank_sel;   // Bank being drained

    // Reader always works on the bank the writer is not using
    assign rd_bank_sel = ~wr_bank_sel_i;

    // =========================================================================
    // Write port
    // =========================================================================
    // Sample lands in the bank named by the select
    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem_q[wr_bank_sel_i][wr_i.addr] <= wr_i.data;
        end
    end

    // =========================================================================
    // Read port
    // =========================================================================
    // Asynchronous read, data follows the address in the same cycle
    // Bank and address only move on a read handshake or swap
    // so data stays put while the consumer stalls
    assign rd_data_o = mem_q[rd_bank_sel][rd_addr_i];

    // Bank swap and write never touch the read bank together
    // since a swap only follows a finished drain

endmodule

`default_nettype wire

//--- hw/pp_cfg_pkg.sv
`default_nettype none

package pp_cfg_pkg;

    // =========================================================================
    // Sizing
    // =========================================================================
    localparam int WIDTH  = 32;              // Bits per sample
    localparam int DEPTH  = 16;              // Samples held by one bank
    localparam int ADDR_W = $clog2(DEPTH);   // Address bits inside one bank
    localparam int CNT_W  = ADDR_W + 1;      // Extra bit so the value DEPTH fits

    // =========================================================================
    // Types
    // =========================================================================
    typedef logic signed [WIDTH-1:0] sample_t;   // Two's complement sample
    typedef logic [ADDR_W-1:0]       addr_t;     // Location within one bank
    typedef logic [CNT_W-1:0]        count_t;    // Fill level or drain position, 0..DEPTH

    // Drain FSM
    typedef enum logic {
        DRAIN_IDLE   = 1'b0,   // No block pending
        DRAIN_ACTIVE = 1'b1    // Full bank on its way to the consumer
    } drain_state_t;

endpackage

`default_nettype wire

//--- hw/pp_port_pkg.sv
`default_nettype none

package pp_port_pkg;

    // =========================================================================
    // Bank write port
    // =========================================================================
    // One sample on its way into the bank currently being filled
    typedef struct packed {
        logic                en;     // Write strobe, one per accepted sample
        pp_cfg_pkg::addr_t   addr;   // Slot inside the write bank
        pp_cfg_pkg::sample_t data;   // Sample as received from the producer
    } bank_wr_t;

    // =========================================================================
    // Status
    // =========================================================================
    // Collected for the outside world at the top level
    typedef struct packed {
        logic                block_ready;   // One-cycle pulse on every swap
        pp_cfg_pkg::count_t  write_count;   // Samples in the write bank
        pp_cfg_pkg::count_t  read_count;    // Samples already drained
    } pp_status_t;

    // Field order puts the pulse in the MSB
    // Counts follow as two equal fields

endpackage

`default_nettype wire

//--- hw/pp_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pp_read_ctrl (
    input  wire logic            clk_i,
    input  wire logic            rst_ni,
    input  wire logic            read_ready_i,   // Consumer takes a sample
    input  wire logic            swap_i,         // New block to drain
    output logic                 read_valid_o,
    output logic                 idle_o,         // Free to accept the next block
    output pp_cfg_pkg::addr_t    rd_addr_o,      // Slot in the read bank
    output pp_cfg_pkg::count_t   read_count_o
);

    pp_cfg_pkg::drain_state_t state_q;
    pp_cfg_pkg::addr_t        rd_addr_q;
    pp_cfg_pkg::count_t       rd_count_q;     // Transfers done in this drain
    logic                     accept;
    logic                     last;           // Final sample of the block

    // =========================================================================
    // Outputs
    // =========================================================================
    assign read_valid_o = (state_q == pp_cfg_pkg::DRAIN_ACTIVE);
    assign idle_o       = (state_q == pp_cfg_pkg::DRAIN_IDLE);
    assign rd_addr_o    = rd_addr_q;
    assign read_count_o = rd_count_q;

    assign accept = read_valid_o & read_ready_i;
    assign last   = (rd_count_q == pp_cfg_pkg::count_t'(pp_cfg_pkg::DEPTH - 1));

    // =========================================================================
    // Drain FSM
    // =========================================================================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q    <= pp_cfg_pkg::DRAIN_IDLE;
            rd_addr_q  <= '0;
            rd_count_q <= '0;
        end else if (swap_i) begin
            state_q    <= pp_cfg_pkg::DRAIN_ACTIVE;   // Valid rises right after swap
            rd_addr_q  <= '0;
            rd_count_q <= '0;
        end else if (accept) begin
            if (last) begin
                state_q    <= pp_cfg_pkg::DRAIN_IDLE;   // Block done
                rd_addr_q  <= '0;
                rd_count_q <= '0;
            end else begin
                rd_addr_q  <= rd_addr_q + pp_cfg_pkg::addr_t'(1);
                rd_count_q <= rd_count_q + pp_cfg_pkg::count_t'(1);
            end
        end
    end

    // Swap decision upstream must wait for the drain to finish
    a_no_swap_active : assert property (@(posedge clk_i) disable iff (!rst_ni)
        swap_i |-> state_q == pp_cfg_pkg::DRAIN_IDLE);

endmodule

`default_nettype wire

//--- hw/pp_swap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pp_swap_ctrl (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic full_i,          // Write bank holds a whole block
    input  wire logic idle_i,          // Previous block fully drained
    output logic      swap_o,          // Exchange banks on this edge
    output logic      wr_bank_sel_o,   // Bank being filled
    output logic      block_ready_o    // One-cycle notice of a new block
);

    logic bank_sel_q;

    // =========================================================================
    // Swap decision
    // =========================================================================
    // Both conditions must hold on the same edge
    // A stalled reader keeps idle low, so the full bank just waits
    assign swap_o        = full_i & idle_i;
    assign wr_bank_sel_o = bank_sel_q;

    // =========================================================================
    // Bank select
    // =========================================================================
    // Starts on bank 0, flips on every swap
    // The just-filled bank becomes the read bank
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            bank_sel_q <= 1'b0;
        end else if (swap_o) begin
            bank_sel_q <= ~bank_sel_q;
        end
    end

    // =========================================================================
    // Block-ready pulse
    // =========================================================================
    // Registered, so it lines up with read valid going high
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            block_ready_o <= 1'b0;
        end else begin
            block_ready_o <= swap_o;   // Full drops on swap, so one cycle only
        end
    end

    // Write side must clear full on the swap edge
    a_pulse_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
        block_ready_o |=> !block_ready_o);

endmodule

`default_nettype wire

//--- hw/pp_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pp_write_ctrl (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  write_valid_i,   // Producer has a sample
    input  wire pp_cfg_pkg::sample_t   write_data_i,
    input  wire logic                  swap_i,          // Banks exchange roles
    output logic                       write_ready_o,   // Room left in write bank
    output logic                       full_o,          // Write bank holds DEPTH samples
    output pp_port_pkg::bank_wr_t      wr_o,            // Write into the current bank
    output pp_cfg_pkg::count_t         write_count_o
);

    pp_cfg_pkg::addr_t  wr_addr_q;     // Next free slot
    pp_cfg_pkg::count_t wr_count_q;    // Samples stored since last swap
    logic               accept;        // Handshake completes this cycle

    // =========================================================================
    // Handshake
    // =========================================================================
    assign full_o        = (wr_count_q == pp_cfg_pkg::count_t'(pp_cfg_pkg::DEPTH));
    assign write_ready_o = ~full_o;                  // Count never passes DEPTH
    assign accept        = write_valid_i & write_ready_o;
    assign write_count_o = wr_count_q;

    // Sample goes straight into the bank on the accepting edge
    always_comb begin
        wr_o.en   = accept;
        wr_o.addr = wr_addr_q;
        wr_o.data = write_data_i;
    end

    // =========================================================================
    // Address and fill counter
    // =========================================================================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_addr_q  <= '0;
            wr_count_q <= '0;
        end else if (swap_i) begin
            // Fresh bank, start again at slot 0
            wr_addr_q  <= '0;
            wr_count_q <= '0;
        end else if (accept) begin
            wr_addr_q  <= wr_addr_q + pp_cfg_pkg::addr_t'(1);
            wr_count_q <= wr_count_q + pp_cfg_pkg::count_t'(1);
        end
    end

    // Swap only takes a full bank, so no accepted write is lost on that edge
    a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        swap_i |-> full_o && !wr_o.en);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the ping-pong buffer testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pingpong_buffer -f all.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee "$LOG" \
    || echo "Build or simulation did not complete"

grep -qx "Regression passed" "$LOG" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }

//--- testbench/pp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pp_checker (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire pp_cfg_pkg::sample_t     write_data_i,
    input  wire logic                    write_valid_i,
    input  wire logic                    write_ready_i,
    input  wire pp_cfg_pkg::sample_t     read_data_i,
    input  wire logic                    read_valid_i,
    input  wire logic                    read_ready_i,
    input  wire pp_port_pkg::pp_status_t status_i,
    input  wire logic                    bp_phase_i,    // Reader held off on purpose
    input  wire logic                    report_i,      // Traffic finished, print results
    output int                           writes_o,      // Accepted writes so far
    output int                           reads_o,       // Accepted reads so far
    output int                           failed_o,      // Tests with at least one error
    output logic                         reported_o
);

    // ========================================================================
    // Test bookkeeping
    // ========================================================================
    localparam int T_RESET   = 0;
    localparam int T_ORDER   = 1;
    localparam int T_BLOCK   = 2;
    localparam int T_BP      = 3;
    localparam int T_STALL   = 4;
    localparam int T_COUNT   = 5;
    localparam int NUM_TESTS = 6;

    string               names  [NUM_TESTS];
    int                  errors [NUM_TESTS];
    int                  checks [NUM_TESTS];
    pp_cfg_pkg::sample_t wr_hist [$];     // Every accepted write, oldest first
    int                  n_reads;
    int                  n_pulses;        // block_ready pulses seen
    int                  bp_writes;       // Writes taken during the stall phase

    // Reference state of the buffer
    int                  m_wcount;        // Fill level of the write bank
    int                  m_rcount;        // Position in the current drain
    logic                m_active;        // Drain in progress
    logic                m_pulse;         // Swap on the previous edge

    logic                reset_seen;
    logic                prev_stall;      // Valid high, ready low last cycle
    logic                prev_bp;
    pp_cfg_pkg::sample_t prev_data;

    initial begin
        names[T_RESET] = "reset_state";
        names[T_ORDER] = "order";
        names[T_BLOCK] = "block_boundary";
        names[T_BP]    = "back_pressure";
        names[T_STALL] = "stall_stability";
        names[T_COUNT] = "status_counts";
    end

    // Blocks leave in the order they were filled, samples too
    // so read number idx must return write number idx
    function automatic pp_cfg_pkg::sample_t expected_sample(int idx);
        int blk;
        int slot;
        blk  = idx / pp_cfg_pkg::DEPTH;
        slot = idx % pp_cfg_pkg::DEPTH;
        return wr_hist[blk * pp_cfg_pkg::DEPTH + slot];
    endfunction

    // Whole block holding read number idx already written
    function automatic logic block_complete(int idx);
        return ((idx / pp_cfg_pkg::DEPTH) + 1) * pp_cfg_pkg::DEPTH <= wr_hist.size();
    endfunction

    task automatic check_value(int test, string what, int exp, int act);
        checks[test]++;
        if (exp != act) begin
            errors[test]++;
            $display("ERROR %s (%s): expected %0d, actual %0d", names[test], what, exp, act);
        end
    endtask

    task automatic report_problem(int test, string what);
        checks[test]++;
        errors[test]++;
        $display("Failure in %s: %s", names[test], what);
    endtask

    task automatic report_test(int test);
        if (errors[test] == 0) begin
            $display("Test %s: ok, %0d checks", names[test], checks[test]);
        end else begin
            $display("Test %s: FAILED, %0d of %0d checks wrong",
                     names[test], errors[test], checks[test]);
            failed_o++;
        end
    endtask

    // ========================================================================
    // Per-cycle checks
    // ========================================================================
    task automatic check_reset_state();
        check_value(T_RESET, "read_valid_o", 0, int'(read_valid_i));
        check_value(T_RESET, "block_ready", 0, int'(status_i.block_ready));
        check_value(T_RESET, "write_count", 0, int'(status_i.write_count));
        check_value(T_RESET, "read_count", 0, int'(status_i.read_count));
        check_value(T_RESET, "write_ready_o", 1, int'(write_ready_i));
    endtask

    task automatic check_status();
        check_value(T_COUNT, "write_count", m_wcount, int'(status_i.write_count));
        check_value(T_COUNT, "read_count", m_rcount, int'(status_i.read_count));
        check_value(T_BP, "write_ready_o", int'(m_wcount < pp_cfg_pkg::DEPTH),
                    int'(write_ready_i));
        check_value(T_BLOCK, "block_ready", int'(m_pulse), int'(status_i.block_ready));
        check_value(T_BLOCK, "read_valid_o", int'(m_active), int'(read_valid_i));
        if (status_i.block_ready) begin
            n_pulses++;   // One pulse per DEPTH writes
            check_value(T_BLOCK, "writes at block_ready", n_pulses * pp_cfg_pkg::DEPTH,
                        wr_hist.size());
        end
    endtask

    task automatic check_stall();
        if (prev_stall) begin
            check_value(T_STALL, "read_valid_o held", 1, int'(read_valid_i));
            check_value(T_STALL, "read_data_o held", int'(prev_data), int'(read_data_i));
        end
        prev_stall = read_valid_i && !read_ready_i;
        prev_data  = read_data_i;
    endtask

    task automatic check_read();
        if (!block_complete(n_reads)) begin
            report_problem(T_BLOCK,
                $sformatf("read %0d accepted before its block was written", n_reads));
        end else begin
            check_value(T_ORDER, $sformatf("sample %0d", n_reads),
                        int'(expected_sample(n_reads)), int'(read_data_i));
        end
        n_reads++;
    endtask

    task automatic record_write();
        wr_hist.push_back(write_data_i);
        if (bp_phase_i) begin
            bp_writes++;
            if (bp_writes > 2 * pp_cfg_pkg::DEPTH) begin
                report_problem(T_BP, "write accepted while both banks held unread data");
            end
        end
    endtask

    // Swap on the first edge with a full write bank and no drain running
    task automatic update_model();
        logic swap;
        swap    = (m_wcount == pp_cfg_pkg::DEPTH) && !m_active;
        m_pulse = swap;
        if (swap) begin
            m_wcount = 0;
            m_rcount = 0;
            m_active = 1'b1;
        end else begin
            if (write_valid_i && m_wcount < pp_cfg_pkg::DEPTH) m_wcount++;
            if (m_active && read_ready_i) begin
                if (m_rcount == pp_cfg_pkg::DEPTH - 1) begin
                    m_rcount = 0;        // Last sample of the block
                    m_active = 1'b0;
                end else begin
                    m_rcount++;
                end
            end
        end
    endtask

    task automatic final_report();
        int total;
        total = 0;
        check_value(T_BLOCK, "block_ready pulses", wr_hist.size() / pp_cfg_pkg::DEPTH,
                    n_pulses);
        for (int t = T_ORDER; t < NUM_TESTS; t++) begin
            report_test(t);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += checks[t];
        end
        $display("Summary: %0d tests, %0d ok, %0d failed, %0d checks, %0d samples",
                 NUM_TESTS, NUM_TESTS - failed_o, failed_o, total, n_reads);
        reported_o = 1'b1;
    endtask

    // ========================================================================
    // Compare process
    // ========================================================================
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                errors[t] = 0;
                checks[t] = 0;
            end
            wr_hist.delete();
            n_reads    = 0;
            n_pulses   = 0;
            bp_writes  = 0;
            m_wcount   = 0;
            m_rcount   = 0;
            m_active   = 1'b0;
            m_pulse    = 1'b0;
            reset_seen = 1'b0;
            prev_stall = 1'b0;
            prev_bp    = 1'b0;
            prev_data  = '0;
            failed_o   = 0;
            reported_o = 1'b0;
        end else begin
            if (!reset_seen) begin
                check_reset_state();             // First cycle out of reset
                report_test(T_RESET);
                reset_seen = 1'b1;
            end
            check_status();
            check_stall();
            if (read_valid_i && read_ready_i) check_read();
            if (bp_phase_i && !prev_bp) bp_writes = 0;
            if (prev_bp && !bp_phase_i) begin
                check_value(T_BP, "writes accepted under stall", 2 * pp_cfg_pkg::DEPTH,
                            bp_writes);
            end
            if (write_valid_i && write_ready_i) record_write();
            update_model();
            prev_bp = bp_phase_i;
            if (report_i && !reported_o) final_report();
        end
        writes_o = wr_hist.size();
        reads_o  = n_reads;
    end

endmodule

`default_nettype wire

//--- testbench/tb_pingpong_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pingpong_buffer;

    localparam int unsigned SEED         = 32'h979a_49c4;
    localparam int          RAND_SAMPLES = 8 * pp_cfg_pkg::DEPTH;  // Whole blocks only
    localparam int          HOLD_CYCLES  = 40;     // Stall kept after both banks fill
    localparam int          STEP_LIMIT   = 4000;   // Cycles allowed per wait
    localparam int          REPORT_LIMIT = 20;

    logic                    clk_i;
    logic                    rst_ni;
    pp_cfg_pkg::sample_t     write_data;
    logic                    write_valid;
    logic                    write_ready;
    pp_cfg_pkg::sample_t     read_data;
    logic                    read_valid;
    logic                    read_ready;
    pp_port_pkg::pp_status_t status;

    logic bp_phase;      // Reader stalled, producer pushing
    logic report_req;
    logic reported;
    logic timed_out;
    int   writes;
    int   reads;
    int   failed;

    // ========================================================================
    // Clock, DUT and checker
    // ========================================================================
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;   // 4 ns period
    end

    pingpong_buffer u_pingpong_buffer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_data_i  (write_data),
        .write_valid_i (write_valid),
        .write_ready_o (write_ready),
        .read_data_o   (read_data),
        .read_valid_o  (read_valid),
        .read_ready_i  (read_ready),
        .status_o      (status)
    );

    pp_checker u_checker (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_data_i  (write_data),
        .write_valid_i (write_valid),
        .write_ready_i (write_ready),
        .read_data_i   (read_data),
        .read_valid_i  (read_valid),
        .read_ready_i  (read_ready),
        .status_i      (status),
        .bp_phase_i    (bp_phase),
        .report_i      (report_req),
        .writes_o      (writes),
        .reads_o       (reads),
        .failed_o      (failed),
        .reported_o    (reported)
    );

    // ========================================================================
    // Stimulus phases, all driven on the falling edge
    // ========================================================================
    task automatic run_random();
        int cycles;
        cycles = 0;
        while (reads < RAND_SAMPLES && cycles < STEP_LIMIT) begin
            @(negedge clk_i);
            write_valid = (writes < RAND_SAMPLES) ? 1'($urandom() & 1) : 1'b0;
            write_data  = pp_cfg_pkg::sample_t'($urandom());
            read_ready  = 1'($urandom() & 1);
            cycles++;
        end
        write_valid = 1'b0;
        read_ready  = 1'b0;
        if (reads < RAND_SAMPLES) begin
            timed_out = 1'b1;
            $display("Timeout: random traffic read back %0d of %0d samples", reads, RAND_SAMPLES);
        end
    endtask

    // Reader off, producer always valid, both banks must fill and then block
    task automatic run_back_pressure();
        int cycles;
        int target;
        cycles      = 0;
        target      = writes + 2 * pp_cfg_pkg::DEPTH;
        bp_phase    = 1'b1;
        write_valid = 1'b1;
        while (writes < target && cycles < STEP_LIMIT) begin
            @(negedge clk_i);
            write_data = pp_cfg_pkg::sample_t'($urandom());
            cycles++;
        end
        if (writes < target) begin
            timed_out = 1'b1;
            $display("Timeout: only %0d writes accepted under back-pressure",
                     writes - target + 2 * pp_cfg_pkg::DEPTH);
        end else begin
            repeat (HOLD_CYCLES) begin
                @(negedge clk_i);
                write_data = pp_cfg_pkg::sample_t'($urandom());
            end
        end
        write_valid = 1'b0;
        bp_phase    = 1'b0;
    endtask

    task automatic run_final_drain();
        int cycles;
        int target;
        cycles = 0;
        target = writes;
        while (reads < target && cycles < STEP_LIMIT) begin
            @(negedge clk_i);
            read_ready = 1'($urandom() & 1);
            cycles++;
        end
        read_ready = 1'b0;
        if (reads < target) begin
            timed_out = 1'b1;
            $display("Timeout: drain stopped at %0d of %0d samples", reads, target);
        end
    endtask

    task automatic request_report();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        report_req = 1'b1;
        while (!reported && cycles < REPORT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!reported) begin
            timed_out = 1'b1;
            $display("Timeout: checker never delivered its summary");
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_ni      = 1'b0;
        write_data  = '0;
        write_valid = 1'b0;
        read_ready  = 1'b0;
        bp_phase    = 1'b0;
        report_req  = 1'b0;
        timed_out   = 1'b0;
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        run_random();
        if (!timed_out) run_back_pressure();
        if (!timed_out) run_final_drain();
        if (!timed_out) request_report();

        if (timed_out || failed != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire
